//--- hdl/fm_pkg.sv
// tone generator shared definitions
`default_nettype none

package fm_pkg;

    localparam int NUM_CH       = 4;
    localparam int NUM_CREDITS  = 4;
    localparam int FRAME_CYCLES = 8; // min cycles between frame starts
    localparam int WAVE_SHIFT   = 6;
    localparam int CH_W         = $clog2(NUM_CH);
    localparam int CYC_W        = $clog2(FRAME_CYCLES);
    localparam int CREDIT_W     = $clog2(NUM_CREDITS + 1);
    localparam int TMRA_MAX     = 1023;
    localparam int TMRB_MAX     = 255;

    // host register map, per-channel entries are bases
    typedef enum logic [7:0] {
        KEYON    = 8'h08,
        TMRA_HI  = 8'h10,
        TMRA_LO  = 8'h11,
        TMRB     = 8'h12,
        TMR_CTRL = 8'h14,
        PAN_BASE = 8'h20,
        INC_HI   = 8'h28,
        INC_LO   = 8'h30,
        ATK      = 8'h38,
        REL      = 8'h40
    } fm_reg_e;

    typedef enum logic [1:0] {
        WAIT_CREDIT,
        SLOT,
        FLUSH
    } fm_seq_e;

    typedef struct packed {
        logic            valid;
        logic [CH_W-1:0] ch;
        logic [15:0]     inc;
        logic [7:0]      atk;
        logic [7:0]      rel;
        logic            key;
        logic [1:0]      pan;  // bit 1 right, bit 0 left
        logic            last;
    } fm_slot_t;

    typedef struct packed {
        logic        valid;
        logic [15:0] phase;
        logic [7:0]  level;
        logic [1:0]  pan;
        logic        last;
    } fm_op_t;

    typedef struct packed {
        logic               valid;
        logic signed [15:0] left;
        logic signed [15:0] right;
    } fm_sample_t;

    typedef struct packed {
        logic [9:0] value_a;
        logic [7:0] value_b;
        logic       load_a;
        logic       load_b;
        logic       irq_en_a;
        logic       irq_en_b;
        logic       clr_a;
        logic       clr_b;
    } fm_tmr_cfg_t;

endpackage

`default_nettype wire

//--- hdl/fm_ctrl.sv
// register file and slot sequencer
`timescale 1ns/100ps
`default_nettype none

module fm_ctrl (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  cs_n,
    input  wire                  wr_n,
    input  wire                  a0,
    input  wire [7:0]            din,
    input  wire                  credit,
    output fm_pkg::fm_slot_t     slot,
    output logic                 frame_tick,
    output fm_pkg::fm_tmr_cfg_t  tmr_cfg
);

    logic [7:0]                   addr_q;
    logic [fm_pkg::NUM_CH-1:0]    key_q;
    logic [1:0]                   pan_q [fm_pkg::NUM_CH];
    logic [15:0]                  inc_q [fm_pkg::NUM_CH];
    logic [7:0]                   atk_q [fm_pkg::NUM_CH];
    logic [7:0]                   rel_q [fm_pkg::NUM_CH];
    fm_pkg::fm_seq_e              state_q;
    logic [fm_pkg::CYC_W-1:0]     cyc_q;    // cycles since frame start
    logic [fm_pkg::CREDIT_W-1:0]  credits_q;
    fm_pkg::fm_reg_e              reg_sel;
    logic [fm_pkg::CH_W-1:0]      wch;
    logic [fm_pkg::CH_W-1:0]      sch;
    logic                         wr;
    logic                         start;

    assign wr  = !cs_n && !wr_n;
    assign wch = addr_q[fm_pkg::CH_W-1:0];

    // per-channel registers sit on 4-aligned bases from 0x20 up
    assign reg_sel = (addr_q[7:5] != 3'd0) ? fm_pkg::fm_reg_e'({addr_q[7:2], 2'b00})
                                           : fm_pkg::fm_reg_e'(addr_q);

    always_ff @(posedge clk) begin
        tmr_cfg.load_a <= 1'b0; // pulses
        tmr_cfg.load_b <= 1'b0;
        tmr_cfg.clr_a  <= 1'b0;
        tmr_cfg.clr_b  <= 1'b0;
        if (reset) begin
            addr_q  <= '0;
            key_q   <= '0;
            tmr_cfg <= '0;
            for (int i = 0; i < fm_pkg::NUM_CH; i++) begin
                pan_q[i] <= '0;
                inc_q[i] <= '0;
                atk_q[i] <= '0;
                rel_q[i] <= '0;
            end
        end else if (wr && !a0) begin
            addr_q <= din; // address phase
        end else if (wr) begin
            case (reg_sel)
                fm_pkg::KEYON:    key_q <= din[fm_pkg::NUM_CH-1:0];
                fm_pkg::TMRA_HI:  tmr_cfg.value_a[9:8] <= din[1:0];
                fm_pkg::TMRA_LO:  tmr_cfg.value_a[7:0] <= din;
                fm_pkg::TMRB:     tmr_cfg.value_b <= din;
                fm_pkg::TMR_CTRL: begin
                    tmr_cfg.load_a   <= din[0];
                    tmr_cfg.load_b   <= din[1];
                    tmr_cfg.irq_en_a <= din[2];
                    tmr_cfg.irq_en_b <= din[3];
                    tmr_cfg.clr_a    <= din[4];
                    tmr_cfg.clr_b    <= din[5];
                end
                fm_pkg::PAN_BASE: pan_q[wch] <= din[7:6];
                fm_pkg::INC_HI:   inc_q[wch][15:8] <= din;
                fm_pkg::INC_LO:   inc_q[wch][7:0] <= din;
                fm_pkg::ATK:      atk_q[wch] <= din;
                fm_pkg::REL:      rel_q[wch] <= din;
                default: ;        // unmapped address
            endcase
        end
    end

    // a frame needs one credit in hand
    assign start      = (state_q == fm_pkg::WAIT_CREDIT) && (credits_q != '0);
    assign frame_tick = start;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= fm_pkg::WAIT_CREDIT;
            cyc_q     <= '0;
            credits_q <= fm_pkg::CREDIT_W'(fm_pkg::NUM_CREDITS);
        end else begin
            credits_q <= credits_q + fm_pkg::CREDIT_W'(credit) - fm_pkg::CREDIT_W'(start);
            case (state_q)
                fm_pkg::WAIT_CREDIT: begin
                    if (start) begin
                        state_q <= fm_pkg::SLOT;
                        cyc_q   <= fm_pkg::CYC_W'(1);
                    end
                end
                fm_pkg::SLOT: begin
                    cyc_q <= cyc_q + 1'b1;
                    if (cyc_q == fm_pkg::CYC_W'(fm_pkg::NUM_CH))
                        state_q <= fm_pkg::FLUSH;
                end
                fm_pkg::FLUSH: begin
                    cyc_q <= cyc_q + 1'b1;
                    if (cyc_q == fm_pkg::CYC_W'(fm_pkg::FRAME_CYCLES - 1))
                        state_q <= fm_pkg::WAIT_CREDIT;
                end
                default: state_q <= fm_pkg::WAIT_CREDIT;
            endcase
        end
    end

    assign sch = fm_pkg::CH_W'(cyc_q - 1'b1); // slot cycles 1..4 carry channels 0..3

    always_comb begin
        slot.valid = (state_q == fm_pkg::SLOT);
        slot.ch    = sch;
        slot.inc   = inc_q[sch];
        slot.atk   = atk_q[sch];
        slot.rel   = rel_q[sch];
        slot.key   = key_q[sch];
        slot.pan   = pan_q[sch];
        slot.last  = (sch == fm_pkg::CH_W'(fm_pkg::NUM_CH - 1));
    end

endmodule

`default_nettype wire

//--- hdl/fm_phase.sv
// per-channel phase accumulators
`timescale 1ns/100ps
`default_nettype none

module fm_phase (
    input  wire               clk,
    input  wire               reset,
    input  fm_pkg::fm_slot_t  slot,
    output logic [15:0]       phase
);

    logic [15:0] acc_q [fm_pkg::NUM_CH];
    logic [15:0] next_phase;

    assign next_phase = acc_q[slot.ch] + slot.inc; // wraps mod 2^16

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < fm_pkg::NUM_CH; i++) begin
                acc_q[i] <= '0;
            end
            phase <= '0;
        end else if (slot.valid) begin
            acc_q[slot.ch] <= next_phase;
            phase          <= next_phase;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fm_env.sv
// linear attack and release envelope
`timescale 1ns/100ps
`default_nettype none

module fm_env (
    input  wire               clk,
    input  wire               reset,
    input  fm_pkg::fm_slot_t  slot,
    output fm_pkg::fm_op_t    op
);

    logic [7:0] lvl_q [fm_pkg::NUM_CH];
    logic [8:0] up;
    logic [8:0] down;
    logic [7:0] next_lvl;

    always_comb begin
        up   = {1'b0, lvl_q[slot.ch]} + {1'b0, slot.atk};
        down = {1'b0, lvl_q[slot.ch]} - {1'b0, slot.rel}; // bit 8 set on underflow
        if (slot.key)
            next_lvl = up[8] ? 8'hff : up[7:0];
        else
            next_lvl = down[8] ? 8'h00 : down[7:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < fm_pkg::NUM_CH; i++) begin
                lvl_q[i] <= '0;
            end
            op <= '0;
        end else begin
            op.valid <= slot.valid;
            if (slot.valid) begin
                lvl_q[slot.ch] <= next_lvl;
                op.level       <= next_lvl;
                op.pan         <= slot.pan;
                op.last        <= slot.last;
            end
        end
    end

    // op.phase stays zero here, the top level merges in the phase stage

endmodule

`default_nettype wire

//--- hdl/fm_wave.sv
// triangle operator with envelope scaling
`timescale 1ns/100ps
`default_nettype none

module fm_wave (
    input  wire                 clk,
    input  wire                 reset,
    input  fm_pkg::fm_op_t      op,
    output logic signed [15:0]  value,
    output logic [1:0]          pan,
    output logic                valid,
    output logic                last
);

    logic [11:0]        p;
    logic [10:0]        m;
    logic signed [12:0] tri_v;   // -2047..2047
    logic signed [21:0] prod;
    logic signed [21:0] scaled;

    always_comb begin
        p      = op.phase[15:4];
        m      = p[11] ? ~p[10:0] : p[10:0]; // fold second half
        tri_v  = $signed({1'b0, m, 1'b0}) - 13'sd2047;
        prod   = tri_v * $signed({1'b0, op.level});
        scaled = prod >>> fm_pkg::WAVE_SHIFT;
    end

    always_ff @(posedge clk) begin
        value <= scaled[15:0];
        pan   <= op.pan;
        last  <= op.last;
        if (reset)
            valid <= 1'b0;
        else
            valid <= op.valid;
    end

endmodule

`default_nettype wire

//--- hdl/fm_mix.sv
// stereo mixer
`timescale 1ns/100ps
`default_nettype none

module fm_mix (
    input  wire                 clk,
    input  wire                 reset,
    input  wire signed [15:0]   value,
    input  wire [1:0]           pan,
    input  wire                 valid,
    input  wire                 last,
    output fm_pkg::fm_sample_t  sample
);

    logic signed [15:0] acc_l;
    logic signed [15:0] acc_r;
    logic signed [15:0] sum_l;
    logic signed [15:0] sum_r;

    // running sums including the channel now arriving
    always_comb begin
        sum_l = acc_l + (pan[0] ? value : 16'sd0);
        sum_r = acc_r + (pan[1] ? value : 16'sd0);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_l <= '0;
            acc_r <= '0;
        end else if (valid) begin
            if (last) begin
                acc_l <= '0; // frame done
                acc_r <= '0;
            end else begin
                acc_l <= sum_l;
                acc_r <= sum_r;
            end
        end
    end

    // the frame's sample leaves with its last channel
    always_comb begin
        sample.valid = valid && last;
        sample.left  = sum_l;
        sample.right = sum_r;
    end

endmodule

`default_nettype wire

//--- hdl/fm_timers.sv
// interval timers A and B
`timescale 1ns/100ps
`default_nettype none

module fm_timers (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  frame_tick,
    input  fm_pkg::fm_tmr_cfg_t  tmr_cfg,
    output logic                 flag_a,
    output logic                 flag_b,
    output logic                 irq_n
);

    // index 0 is timer A, index 1 is timer B
    logic [9:0] cnt_q [2];
    logic [9:0] val_v [2];
    logic [9:0] top_v [2];
    logic [1:0] flag_q;
    logic [1:0] load;
    logic [1:0] clr;
    logic [1:0] irq_en;

    always_comb begin
        val_v[0] = tmr_cfg.value_a;
        val_v[1] = {2'b00, tmr_cfg.value_b};
        top_v[0] = 10'(fm_pkg::TMRA_MAX);
        top_v[1] = 10'(fm_pkg::TMRB_MAX);
        load     = {tmr_cfg.load_b, tmr_cfg.load_a};
        clr      = {tmr_cfg.clr_b, tmr_cfg.clr_a};
        irq_en   = {tmr_cfg.irq_en_b, tmr_cfg.irq_en_a};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_q[0] <= '0;
            cnt_q[1] <= '0;
            flag_q   <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (load[i]) begin
                    cnt_q[i] <= val_v[i];
                end else if (frame_tick) begin
                    if (cnt_q[i] == top_v[i])
                        cnt_q[i] <= val_v[i]; // overflow reloads
                    else
                        cnt_q[i] <= cnt_q[i] + 1'b1;
                end
                if (clr[i])
                    flag_q[i] <= 1'b0;
                else if (!load[i] && frame_tick && cnt_q[i] == top_v[i])
                    flag_q[i] <= 1'b1; // sticky until cleared
            end
        end
    end

    assign flag_a = flag_q[0];
    assign flag_b = flag_q[1];
    assign irq_n  = ~|(flag_q & irq_en);

endmodule

`default_nettype wire

//--- hdl/fm_top.sv
// four-channel tone generator
`timescale 1ns/100ps
`default_nettype none

module fm_top (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 cs_n,
    input  wire                 wr_n,
    input  wire                 a0,
    input  wire [7:0]           din,
    input  wire                 credit,
    output logic [7:0]          dout,
    output logic                irq_n,
    output fm_pkg::fm_sample_t  sample
);

    fm_pkg::fm_slot_t     slot;
    fm_pkg::fm_tmr_cfg_t  tmr_cfg;
    fm_pkg::fm_op_t       env_op;
    fm_pkg::fm_op_t       op;
    logic                 frame_tick;
    logic [15:0]          phase;
    logic signed [15:0]   value;
    logic [1:0]           pan;
    logic                 wave_valid;
    logic                 wave_last;
    logic                 flag_a;
    logic                 flag_b;

    fm_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .cs_n       (cs_n),
        .wr_n       (wr_n),
        .a0         (a0),
        .din        (din),
        .credit     (credit),
        .slot       (slot),
        .frame_tick (frame_tick),
        .tmr_cfg    (tmr_cfg)
    );

    fm_phase u_phase (.clk(clk), .reset(reset), .slot(slot), .phase(phase));

    fm_env u_env (.clk(clk), .reset(reset), .slot(slot), .op(env_op));

    always_comb begin
        op       = env_op;
        op.phase = phase; // both stages register in the same cycle
    end

    fm_wave u_wave (
        .clk   (clk),
        .reset (reset),
        .op    (op),
        .value (value),
        .pan   (pan),
        .valid (wave_valid),
        .last  (wave_last)
    );

    fm_mix u_mix (
        .clk    (clk),
        .reset  (reset),
        .value  (value),
        .pan    (pan),
        .valid  (wave_valid),
        .last   (wave_last),
        .sample (sample)
    );

    fm_timers u_timers (
        .clk        (clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .tmr_cfg    (tmr_cfg),
        .flag_a     (flag_a),
        .flag_b     (flag_b),
        .irq_n      (irq_n)
    );

    assign dout = {6'b000000, flag_b, flag_a}; // status read

endmodule

`default_nettype wire

//--- tests/fm_model.svh
// tone generator reference model
`ifndef FM_MODEL_SVH
`define FM_MODEL_SVH

logic [3:0]  m_key;
logic [1:0]  m_pan [fm_pkg::NUM_CH];   // bit 1 right, bit 0 left
logic [15:0] m_inc [fm_pkg::NUM_CH];
logic [7:0]  m_atk [fm_pkg::NUM_CH];
logic [7:0]  m_rel [fm_pkg::NUM_CH];
logic [15:0] m_phase [fm_pkg::NUM_CH];
int          m_level [fm_pkg::NUM_CH];
logic [9:0]  m_val_a;
logic [7:0]  m_val_b;
int          m_cnt_a;
int          m_cnt_b;
logic        m_flag_a;
logic        m_flag_b;
logic        m_en_a;
logic        m_en_b;
int          exp_left;
int          exp_right;

task reset_model();
    m_key    = '0;
    m_val_a  = '0;
    m_val_b  = '0;
    m_cnt_a  = 0;
    m_cnt_b  = 0;
    m_flag_a = 1'b0;
    m_flag_b = 1'b0;
    m_en_a   = 1'b0;
    m_en_b   = 1'b0;
    for (int c = 0; c < fm_pkg::NUM_CH; c++) begin
        m_pan[c]   = '0;
        m_inc[c]   = '0;
        m_atk[c]   = '0;
        m_rel[c]   = '0;
        m_phase[c] = '0;
        m_level[c] = 0;
    end
endtask

// one data write at the given register address
task mirror_write(input logic [7:0] addr, input logic [7:0] data);
    int ch;
    ch = int'(addr[1:0]);
    if (addr == 8'h08) begin
        m_key = data[3:0];
    end else if (addr == 8'h10) begin
        m_val_a[9:8] = data[1:0];
    end else if (addr == 8'h11) begin
        m_val_a[7:0] = data;
    end else if (addr == 8'h12) begin
        m_val_b = data;
    end else if (addr == 8'h14) begin
        if (data[0])
            m_cnt_a = int'(m_val_a);
        if (data[1])
            m_cnt_b = int'(m_val_b);
        m_en_a = data[2];
        m_en_b = data[3];
        if (data[4])
            m_flag_a = 1'b0;
        if (data[5])
            m_flag_b = 1'b0;
    end else begin
        case (addr & 8'hfc)
            8'h20: m_pan[ch] = data[7:6];
            8'h28: m_inc[ch][15:8] = data;
            8'h30: m_inc[ch][7:0] = data;
            8'h38: m_atk[ch] = data;
            8'h40: m_rel[ch] = data;
            default: ;
        endcase
    end
endtask

// every channel steps once and then the timers tick
task step_frame();
    logic [11:0] p;
    int          m;
    int          tri_v;
    int          v;
    exp_left  = 0;
    exp_right = 0;
    for (int c = 0; c < fm_pkg::NUM_CH; c++) begin
        m_phase[c] = m_phase[c] + m_inc[c];
        if (m_key[c])
            m_level[c] = (m_level[c] + int'(m_atk[c]) > 255) ? 255 : m_level[c] + int'(m_atk[c]);
        else
            m_level[c] = (m_level[c] < int'(m_rel[c])) ? 0 : m_level[c] - int'(m_rel[c]);
        p     = m_phase[c][15:4];
        m     = p[11] ? 2047 - int'(p[10:0]) : int'(p[10:0]); // mirror second half
        tri_v = 2 * m - 2047;
        v     = (tri_v * m_level[c]) >>> fm_pkg::WAVE_SHIFT;
        if (m_pan[c][0])
            exp_left += v;
        if (m_pan[c][1])
            exp_right += v;
    end
    if (m_cnt_a == 1023) begin
        m_cnt_a  = int'(m_val_a);
        m_flag_a = 1'b1;
    end else begin
        m_cnt_a++;
    end
    if (m_cnt_b == 255) begin
        m_cnt_b  = int'(m_val_b);
        m_flag_b = 1'b1;
    end else begin
        m_cnt_b++;
    end
endtask

function automatic logic expected_irq_n();
    return !((m_flag_a && m_en_a) || (m_flag_b && m_en_b));
endfunction

`endif

//--- tests/fm_tb.sv
// tone generator testbench
`timescale 1ns/100ps
`default_nettype none

module fm_tb;

    logic               clk;
    logic               reset;
    logic               cs_n;
    logic               wr_n;
    logic               a0;
    logic [7:0]         din;
    logic               credit;
    logic [7:0]         dout;
    logic               irq_n;
    fm_pkg::fm_sample_t sample;

    int                 seed;
    int                 samples = 0;
    int                 returned = 0;
    int                 value_errors = 0;
    int                 other_errors = 0;
    int                 mon_value_errors = 0;
    int                 mon_other_errors = 0;
    logic signed [15:0] last_left = '0;
    logic signed [15:0] last_right = '0;
    logic               seen_flag_a = 1'b0;
    logic               seen_flag_b = 1'b0;
    int                 val_a;
    int                 val_b;
    int                 s0;

    `include "fm_model.svh"

    fm_top uut (
        .clk    (clk),
        .reset  (reset),
        .cs_n   (cs_n),
        .wr_n   (wr_n),
        .a0     (a0),
        .din    (din),
        .credit (credit),
        .dout   (dout),
        .irq_n  (irq_n),
        .sample (sample)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // address phase then data phase
    task host_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        cs_n = 1'b0;
        wr_n = 1'b0;
        a0   = 1'b0;
        din  = addr;
        @(posedge clk);
        #1;
        a0  = 1'b1;
        din = data;
        @(posedge clk);
        #1;
        cs_n = 1'b1;
        wr_n = 1'b1;
        a0   = 1'b0;
        mirror_write(addr, data);
        @(posedge clk); // effects land a cycle after the write
        #1;
    endtask

    task check_status(inout int errs);
        assert (dout == {6'b000000, m_flag_b, m_flag_a}) else begin
            errs++;
            $display("FAILED dout: got %h, expected %h", dout, {6'b000000, m_flag_b, m_flag_a});
        end
        assert (irq_n == expected_irq_n()) else begin
            errs++;
            $display("FAILED irq_n: got %h, expected %h", irq_n, expected_irq_n());
        end
    endtask

    task wait_samples(input int target);
        int t;
        t = 0;
        while (samples < target && t < 64 * fm_pkg::FRAME_CYCLES) begin
            @(posedge clk);
            t++;
        end
        assert (samples >= target) else begin
            other_errors++;
            $display("timeout: %0d samples seen, %0d expected", samples, target);
        end
    endtask

    // sink hands back one credit per held sample after a random delay
    task return_credits(input int n);
        int gap;
        int t;
        for (int i = 0; i < n; i++) begin
            t = 0;
            while (returned >= samples && t < 20 * fm_pkg::FRAME_CYCLES) begin
                @(posedge clk);
                t++;
            end
            assert (returned < samples) else begin
                other_errors++;
                $display("timeout: no sample arrived to free a credit");
            end
            gap = $random(seed) & 3;
            if (($random(seed) & 7) == 0)
                gap = gap + 3 * fm_pkg::FRAME_CYCLES; // sink holds its credit a while
            repeat (gap) @(posedge clk);
            @(posedge clk);
            #1;
            credit = 1'b1;
            returned++;
            @(posedge clk);
            #1;
            credit = 1'b0;
        end
        wait_samples(fm_pkg::NUM_CREDITS + returned);
    endtask

    // every valid sample closes one model frame
    always @(negedge clk) begin
        if (!reset && sample.valid) begin
            samples++;
            step_frame();
            assert (sample.left == 16'(exp_left)) else begin
                mon_value_errors++;
                $display("FAILED sample.left: got %h, expected %h", sample.left, 16'(exp_left));
            end
            assert (sample.right == 16'(exp_right)) else begin
                mon_value_errors++;
                $display("FAILED sample.right: got %h, expected %h",
                         sample.right, 16'(exp_right));
            end
            check_status(mon_value_errors);
            assert (samples <= fm_pkg::NUM_CREDITS + returned) else begin
                mon_other_errors++;
                $display("more samples than credits: %0d samples, %0d returned", samples, returned);
            end
            last_left  = sample.left;
            last_right = sample.right;
            if (dout[0])
                seen_flag_a = 1'b1;
            if (dout[1])
                seen_flag_b = 1'b1;
        end
    end

    initial begin
        seed   = 65;
        reset  = 1'b1;
        cs_n   = 1'b1;
        wr_n   = 1'b1;
        a0     = 1'b0;
        din    = '0;
        credit = 1'b0;
        reset_model();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (!sample.valid && irq_n && dout == 8'h00) else begin
            other_errors++;
            $display("outputs not in their reset state after reset");
        end
        wait_samples(fm_pkg::NUM_CREDITS); // frames from the initial credits

        // keys on with random tones
        for (int c = 0; c < fm_pkg::NUM_CH; c++) begin
            host_write(8'h28 + 8'(c), 8'($random(seed)));
            host_write(8'h30 + 8'(c), 8'($random(seed)));
            host_write(8'h38 + 8'(c), 8'(1 + ($random(seed) & 31)));
            host_write(8'h20 + 8'(c), 8'($random(seed)) & 8'hc0);
        end
        host_write(8'h08, 8'h0f);
        return_credits(24);

        // release down to silence
        for (int c = 0; c < fm_pkg::NUM_CH; c++)
            host_write(8'h40 + 8'(c), 8'(8 + ($random(seed) & 31)));
        host_write(8'h08, 8'h00);
        return_credits(40);
        assert (last_left == 16'sd0 && last_right == 16'sd0) else begin
            other_errors++;
            $display("output did not reach silence after key off");
        end

        // stall without credits so phases and levels hold
        host_write(8'h08, 8'h0f);
        return_credits(6);
        s0 = samples;
        repeat (5 * fm_pkg::FRAME_CYCLES) @(posedge clk);
        assert (samples == s0) else begin
            other_errors++;
            $display("a sample appeared while no credit was held");
        end
        return_credits(1);

        // timers near their top values with only the A irq enabled
        val_a = 1023 - ($random(seed) & 15);
        val_b = 255 - ($random(seed) & 15);
        host_write(8'h10, 8'(val_a >> 8));
        host_write(8'h11, 8'(val_a & 255));
        host_write(8'h12, 8'(val_b));
        host_write(8'h14, 8'h07);
        check_status(value_errors);
        return_credits(20);
        assert (seen_flag_a && seen_flag_b) else begin
            other_errors++;
            $display("a timer flag never showed up in dout");
        end
        host_write(8'h14, 8'h14); // clear A
        check_status(value_errors);
        host_write(8'h14, 8'h08); // B irq only
        check_status(value_errors);
        host_write(8'h14, 8'h28); // clear B
        check_status(value_errors);

        $display("errors: %0d value, %0d other", value_errors + mon_value_errors,
                 other_errors + mon_other_errors);
        if (value_errors + mon_value_errors + other_errors + mon_other_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+tests
hdl/fm_pkg.sv
hdl/fm_ctrl.sv
hdl/fm_phase.sv
hdl/fm_env.sv
hdl/fm_wave.sv
hdl/fm_mix.sv
hdl/fm_timers.sv
hdl/fm_top.sv
tests/fm_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the tone generator testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module fm_tb -f flist.f -o fm_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/fm_sim | tee "$log"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$log"; then
    exit 0
else
    echo "pass message not found in $log"
    exit 1
fi
